//--- project.f
rtl/hazard_ctrl_if.sv
rtl/cpu_types_pkg.sv
rtl/pipe_types_pkg.sv
rtl/control_unit.sv
rtl/register_file.sv
rtl/alu.sv
rtl/hazard_unit.sv
rtl/forwarding_unit.sv
rtl/datapath.sv
rtl/cpu_core.sv
verif/tb_clock_gen.sv
verif/tb_cpu_core.sv

//--- rtl/alu.sv
/* ALU */
`timescale 1ns/1ps

module alu
   import cpu_types_pkg::*;
(
   input  aluop_t     alu_op,
   input  word_t      op1,
   input  word_t      op2,
   input  logic [4:0] shamt,
   output word_t      res
);
   logic lt;

   // signed compare for slt
   assign lt = $signed(op1) < $signed(op2);

   always_comb begin
      case (alu_op)
         ALU_ADD: res = op1 + op2;
         ALU_SUB: res = op1 - op2;
         ALU_AND: res = op1 & op2;
         ALU_OR:  res = op1 | op2;
         ALU_SLT: res = {31'b0, lt};
         // shift acts on rt
         ALU_SLL: res = op2 << shamt;
         // upper half from the immediate
         ALU_LUI: res = {op2[15:0], 16'b0};
         default: res = '0;
      endcase
   end
endmodule

//--- rtl/control_unit.sv
/* instruction decoder */
`timescale 1ns/1ps

module control_unit
   import cpu_types_pkg::*;
   import pipe_types_pkg::*;
(
   input  word_t       instr,
   output regbits_t    rs,
   output regbits_t    rt,
   output regbits_t    wsel,
   output logic [15:0] imm16,
   output logic        extop,
   output aluop_t      alu_op,
   output alusrc_t     alu_src,
   output branch_t     branch,
   output logic        jump,
   output logic        regwr,
   output logic        memread,
   output logic        memwrite,
   output logic        memtoreg,
   output logic        halt
);
   opcode_t opcode;
   funct_t  funct;

   assign opcode = opcode_t'(instr[31:26]);
   assign funct  = funct_t'(instr[5:0]);

   // raw register fields
   assign rs    = instr[25:21];
   assign rt    = instr[20:16];
   assign imm16 = instr[15:0];

   always_comb begin
      // no-op unless told otherwise, itype writes rt
      wsel     = instr[20:16];
      extop    = 1'b1;
      alu_op   = ALU_ADD;
      alu_src  = SRC_IMM;
      branch   = BR_NONE;
      jump     = 1'b0;
      regwr    = 1'b0;
      memread  = 1'b0;
      memwrite = 1'b0;
      memtoreg = 1'b0;
      halt     = 1'b0;
      case (opcode)
         RTYPE: begin
            wsel    = instr[15:11];
            alu_src = SRC_REG;
            regwr   = 1'b1;
            case (funct)
               ADDU:    alu_op = ALU_ADD;
               SUBU:    alu_op = ALU_SUB;
               AND:     alu_op = ALU_AND;
               OR:      alu_op = ALU_OR;
               SLT:     alu_op = ALU_SLT;
               SLL:     alu_op = ALU_SLL;
               // unknown funct, keep quiet
               default: regwr  = 1'b0;
            endcase
         end
         ADDIU: regwr = 1'b1;
         ORI: begin
            extop  = 1'b0;
            alu_op = ALU_OR;
            regwr  = 1'b1;
         end
         LUI: begin
            alu_op = ALU_LUI;
            regwr  = 1'b1;
         end
         LW: begin
            regwr    = 1'b1;
            memread  = 1'b1;
            memtoreg = 1'b1;
         end
         SW: memwrite = 1'b1;
         // compare uses rs against rt
         BEQ: begin
            alu_src = SRC_REG;
            branch  = BR_EQ;
         end
         BNE: begin
            alu_src = SRC_REG;
            branch  = BR_NE;
         end
         J:       jump = 1'b1;
         HALT:    halt = 1'b1;
         default: ;
      endcase
   end
endmodule

//--- rtl/cpu_core.sv
/* pipelined MIPS core */
`timescale 1ns/1ps

module cpu_core
   import cpu_types_pkg::*;
#(
   parameter word_t PC_INIT = '0
) (
   input  logic  CLK,
   input  logic  reset,
   input  logic  ihit,
   input  logic  dhit,
   input  word_t imem_load,
   input  word_t dmem_load,
   output word_t imem_addr,
   output word_t dmem_addr,
   output word_t dmem_store,
   output logic  dmem_ren,
   output logic  dmem_wen,
   output logic  halt
);
   // hazard unit to latch controls
   hazard_ctrl_if hz_if ();

   datapath #(
      .PC_INIT(PC_INIT)
   ) u_datapath (
      .CLK,
      .reset,
      .ihit,
      .dhit,
      .imem_load,
      .dmem_load,
      .imem_addr,
      .dmem_addr,
      .dmem_store,
      .dmem_ren,
      .dmem_wen,
      .halt,
      .hz(hz_if)
   );
endmodule

//--- rtl/cpu_types_pkg.sv
/* MIPS core base types */
package cpu_types_pkg;

   //////////////////////////////////////////////////////////////
   // widths
   //////////////////////////////////////////////////////////////
   // data and address word
   typedef logic [31:0] word_t;
   // register index
   typedef logic [4:0] regbits_t;

   //////////////////////////////////////////////////////////////
   // instruction fields
   //////////////////////////////////////////////////////////////
   // primary opcode, bits 31:26
   typedef enum logic [5:0] {
      RTYPE = 6'h00,
      J     = 6'h02,
      BEQ   = 6'h04,
      BNE   = 6'h05,
      ADDIU = 6'h09,
      ORI   = 6'h0d,
      LUI   = 6'h0f,
      LW    = 6'h23,
      SW    = 6'h2b,
      HALT  = 6'h3f
   } opcode_t;

   // rtype function, bits 5:0
   typedef enum logic [5:0] {
      SLL  = 6'h00,
      ADDU = 6'h21,
      SUBU = 6'h23,
      AND  = 6'h24,
      OR   = 6'h25,
      SLT  = 6'h2a
   } funct_t;

   // alu operation select
   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_SLT,
      ALU_SLL,
      ALU_LUI
   } aluop_t;

endpackage

//--- rtl/datapath.sv
/* pipelined datapath */
`timescale 1ns/1ps

module datapath
   import cpu_types_pkg::*;
   import pipe_types_pkg::*;
#(
   parameter word_t PC_INIT = '0
) (
   input  logic  CLK,
   input  logic  reset,
   input  logic  ihit,
   input  logic  dhit,
   input  word_t imem_load,
   input  word_t dmem_load,
   output word_t imem_addr,
   output word_t dmem_addr,
   output word_t dmem_store,
   output logic  dmem_ren,
   output logic  dmem_wen,
   output logic  halt,
   hazard_ctrl_if hz
);
   word_t pc, pc_plus_4;
   fd_t fd_in, fd;
   de_t de_in, de;
   em_t em_in, em;
   mw_t mw_in, mw;
   // decode side
   regbits_t cu_rs, cu_rt, cu_wsel;
   logic [15:0] cu_imm16;
   logic cu_extop, cu_jump, cu_regwr, cu_memread, cu_memwrite, cu_memtoreg, cu_halt;
   aluop_t cu_alu_op;
   alusrc_t cu_alu_src;
   branch_t cu_branch;
   word_t rdat1, rdat2, wb_wdat;
   logic rf_wen;
   // execute side
   fwd_t fwd_op1, fwd_op2;
   word_t ex_op1, ex_rt_val, ex_op2, alu_res, ex_target;
   logic ex_equal, ex_redirect;
   // memory side
   logic mem_req, dacc_done;
   word_t load_hold;

   control_unit u_control (
      .instr(fd.instr), .rs(cu_rs), .rt(cu_rt), .wsel(cu_wsel), .imm16(cu_imm16),
      .extop(cu_extop), .alu_op(cu_alu_op), .alu_src(cu_alu_src), .branch(cu_branch),
      .jump(cu_jump), .regwr(cu_regwr), .memread(cu_memread), .memwrite(cu_memwrite),
      .memtoreg(cu_memtoreg), .halt(cu_halt)
   );
   register_file u_regfile (
      .CLK, .reset, .wen(rf_wen), .wsel(mw.wsel), .wdat(wb_wdat),
      .rsel1(cu_rs), .rsel2(cu_rt), .rdat1, .rdat2
   );
   alu u_alu (
      .alu_op(de.alu_op), .op1(ex_op1), .op2(ex_op2), .shamt(de.imm32[10:6]), .res(alu_res)
   );
   hazard_unit u_hazard (
      .ihit, .dhit, .mem_access(mem_req), .ex_memread(de.memread), .ex_wsel(de.wsel),
      .id_rs(cu_rs), .id_rt(cu_rt), .ex_redirect, .id_halt(cu_halt), .hz(hz)
   );
   forwarding_unit u_forward (
      .ex_rs(de.rs), .ex_rt(de.rt), .mem_wsel(em.wsel), .mem_regwr(em.regwr),
      .wb_wsel(mw.wsel), .wb_regwr(mw.regwr), .fwd_op1, .fwd_op2
   );

   ////////////////////////////////////////////////////////////
   // pc and latches
   ////////////////////////////////////////////////////////////
   assign pc_plus_4 = pc + 32'd4;
   assign imem_addr = pc;

   always_ff @(posedge CLK) begin
      if (reset) begin
         pc <= PC_INIT;
      end else if (hz.pc_en) begin
         pc <= ex_redirect ? ex_target : pc_plus_4;
      end
   end

   // flush beats enable, both dead while frozen
   always_ff @(posedge CLK) begin
      if (reset || hz.fd_flush) begin
         fd <= '0;
      end else if (hz.fd_en) begin
         fd <= fd_in;
      end
   end
   always_ff @(posedge CLK) begin
      if (reset || hz.de_flush) begin
         de <= '0;
      end else if (hz.de_en) begin
         de <= de_in;
      end
   end
   always_ff @(posedge CLK) begin
      if (reset || hz.em_flush) begin
         em <= '0;
      end else if (hz.em_en) begin
         em <= em_in;
      end
   end
   always_ff @(posedge CLK) begin
      if (reset) begin
         mw <= '0;
      end else if (hz.mw_en) begin
         mw <= mw_in;
      end
   end

   ////////////////////////////////////////////////////////////
   // fetch and decode
   ////////////////////////////////////////////////////////////
   assign fd_in.instr     = imem_load;
   assign fd_in.pc_plus_4 = pc_plus_4;

   assign de_in.pc_plus_4 = fd.pc_plus_4;
   assign de_in.rdat1     = rdat1;
   assign de_in.rdat2     = rdat2;
   // sign or zero extension
   assign de_in.imm32     = cu_extop ? {{16{cu_imm16[15]}}, cu_imm16} : {16'b0, cu_imm16};
   assign de_in.rs        = cu_rs;
   assign de_in.rt        = cu_rt;
   // destination mux, non-writers carry r0
   assign de_in.wsel      = cu_regwr ? cu_wsel : '0;
   assign de_in.alu_op    = cu_alu_op;
   assign de_in.alu_src   = cu_alu_src;
   assign de_in.branch    = cu_branch;
   assign de_in.jump      = cu_jump;
   assign de_in.target    = {fd.pc_plus_4[31:28], fd.instr[25:0], 2'b00};
   assign de_in.regwr     = cu_regwr;
   assign de_in.memread   = cu_memread;
   assign de_in.memwrite  = cu_memwrite;
   assign de_in.memtoreg  = cu_memtoreg;
   assign de_in.halt      = cu_halt;

   ////////////////////////////////////////////////////////////
   // execute
   ////////////////////////////////////////////////////////////
   always_comb begin
      case (fwd_op1)
         FWD_MEM: ex_op1 = em.alu_res;
         FWD_WB:  ex_op1 = wb_wdat;
         default: ex_op1 = de.rdat1;
      endcase
   end
   // rt path, also the store data
   always_comb begin
      case (fwd_op2)
         FWD_MEM: ex_rt_val = em.alu_res;
         FWD_WB:  ex_rt_val = wb_wdat;
         default: ex_rt_val = de.rdat2;
      endcase
   end
   assign ex_op2 = (de.alu_src == SRC_IMM) ? de.imm32 : ex_rt_val;

   // branch resolve
   assign ex_equal    = ex_op1 == ex_rt_val;
   assign ex_redirect = de.jump || (de.branch == BR_EQ && ex_equal) ||
                        (de.branch == BR_NE && !ex_equal);
   assign ex_target   = de.jump ? de.target : de.pc_plus_4 + (de.imm32 << 2);

   assign em_in.alu_res    = alu_res;
   assign em_in.store_data = ex_rt_val;
   assign em_in.wsel       = de.wsel;
   assign em_in.regwr      = de.regwr;
   assign em_in.memread    = de.memread;
   assign em_in.memwrite   = de.memwrite;
   assign em_in.memtoreg   = de.memtoreg;
   assign em_in.halt       = de.halt;

   ////////////////////////////////////////////////////////////
   // memory and writeback
   ////////////////////////////////////////////////////////////
   // an access done during an ifetch miss is not repeated
   assign mem_req = (em.memread || em.memwrite) && !dacc_done;
   always_ff @(posedge CLK) begin
      if (reset || hz.em_en) begin
         dacc_done <= 1'b0;
      end else if (mem_req && dhit) begin
         dacc_done <= 1'b1;
      end
   end
   // load word kept until the stage moves on
   always_ff @(posedge CLK) begin
      if (mem_req && dhit) begin
         load_hold <= dmem_load;
      end
   end

   assign dmem_addr  = em.alu_res;
   assign dmem_store = em.store_data;
   assign dmem_ren   = em.memread && !dacc_done;
   assign dmem_wen   = em.memwrite && !dacc_done;

   assign mw_in.alu_res   = em.alu_res;
   assign mw_in.load_data = dacc_done ? load_hold : dmem_load;
   assign mw_in.wsel      = em.wsel;
   assign mw_in.regwr     = em.regwr;
   assign mw_in.memtoreg  = em.memtoreg;
   assign mw_in.halt      = em.halt;

   // write once, on the edge the instruction retires
   assign wb_wdat = mw.memtoreg ? mw.load_data : mw.alu_res;
   assign rf_wen  = mw.regwr && hz.mw_en;
   assign halt    = mw.halt;
endmodule

//--- rtl/forwarding_unit.sv
/* operand forwarding */
`timescale 1ns/1ps

module forwarding_unit
   import cpu_types_pkg::*;
   import pipe_types_pkg::*;
(
   input  regbits_t ex_rs,
   input  regbits_t ex_rt,
   input  regbits_t mem_wsel,
   input  logic     mem_regwr,
   input  regbits_t wb_wsel,
   input  logic     wb_regwr,
   output fwd_t     fwd_op1,
   output fwd_t     fwd_op2
);
   // youngest producer first
   // r0 never forwarded
   function automatic fwd_t pick(input regbits_t src);
      fwd_t sel;
      sel = FWD_NONE;
      if (mem_regwr && mem_wsel != '0 && mem_wsel == src) begin
         sel = FWD_MEM;
      end else if (wb_regwr && wb_wsel != '0 && wb_wsel == src) begin
         sel = FWD_WB;
      end
      return sel;
   endfunction

   // one select per execute operand
   always_comb begin
      fwd_op1 = pick(ex_rs);
      fwd_op2 = pick(ex_rt);
   end
endmodule

//--- rtl/hazard_ctrl_if.sv
/* hazard control bundle */
`timescale 1ns/1ps

interface hazard_ctrl_if;
   // pc update
   logic pc_en;
   // latch enables and squashes
   logic fd_en;
   logic fd_flush;
   logic de_en;
   logic de_flush;
   logic em_en;
   logic em_flush;
   logic mw_en;

   // hazard unit side
   modport unit (
      output pc_en, fd_en, fd_flush, de_en, de_flush, em_en, em_flush, mw_en
   );

   // datapath side
   modport dp (
      input pc_en, fd_en, fd_flush, de_en, de_flush, em_en, em_flush, mw_en
   );
endinterface

//--- rtl/hazard_unit.sv
/* hazard unit */
`timescale 1ns/1ps

module hazard_unit
   import cpu_types_pkg::*;
(
   input  logic     ihit,
   input  logic     dhit,
   input  logic     mem_access,
   input  logic     ex_memread,
   input  regbits_t ex_wsel,
   input  regbits_t id_rs,
   input  regbits_t id_rt,
   input  logic     ex_redirect,
   input  logic     id_halt,
   hazard_ctrl_if.unit hz
);
   logic freeze;
   logic load_use;

   // any memory wait holds everything
   assign freeze = !ihit || (mem_access && !dhit);

   // load in execute feeding decode
   assign load_use = ex_memread && ex_wsel != '0 &&
                     (ex_wsel == id_rs || ex_wsel == id_rt);

   //////////////////////////////////////////////////////////////
   // enables
   //////////////////////////////////////////////////////////////
   // redirect wins over a halt sitting on the wrong path
   assign hz.pc_en = !freeze && (ex_redirect || (!load_use && !id_halt));
   assign hz.fd_en = !freeze && !load_use && !id_halt;
   assign hz.de_en = !freeze;
   assign hz.em_en = !freeze;
   assign hz.mw_en = !freeze;

   //////////////////////////////////////////////////////////////
   // flushes
   //////////////////////////////////////////////////////////////
   assign hz.fd_flush = !freeze && ex_redirect;
   // bubble on load-use or wrong-path decode
   assign hz.de_flush = !freeze && (ex_redirect || load_use);
   // branches resolve in execute, nothing past it squashed
   assign hz.em_flush = 1'b0;
endmodule

//--- rtl/pipe_types_pkg.sv
/* pipeline latch types */
package pipe_types_pkg;
   import cpu_types_pkg::*;

   //////////////////////////////////////////////////////////////
   // mux selects
   //////////////////////////////////////////////////////////////
   typedef enum logic {
      SRC_REG,
      SRC_IMM
   } alusrc_t;

   typedef enum logic [1:0] {
      BR_NONE,
      BR_EQ,
      BR_NE
   } branch_t;

   // operand source in execute
   typedef enum logic [1:0] {
      FWD_NONE,
      FWD_MEM,
      FWD_WB
   } fwd_t;

   //////////////////////////////////////////////////////////////
   // latches
   //////////////////////////////////////////////////////////////
   // fetch to decode
   typedef struct packed {
      word_t instr;
      word_t pc_plus_4;
   } fd_t;

   // decode to execute
   typedef struct packed {
      word_t    pc_plus_4;
      word_t    rdat1;
      word_t    rdat2;
      word_t    imm32;
      regbits_t rs;
      regbits_t rt;
      regbits_t wsel;
      aluop_t   alu_op;
      alusrc_t  alu_src;
      branch_t  branch;
      logic     jump;
      word_t    target;
      logic     regwr;
      logic     memread;
      logic     memwrite;
      logic     memtoreg;
      logic     halt;
   } de_t;

   // execute to memory
   typedef struct packed {
      word_t    alu_res;
      word_t    store_data;
      regbits_t wsel;
      logic     regwr;
      logic     memread;
      logic     memwrite;
      logic     memtoreg;
      logic     halt;
   } em_t;

   // memory to writeback
   typedef struct packed {
      word_t    alu_res;
      word_t    load_data;
      regbits_t wsel;
      logic     regwr;
      logic     memtoreg;
      logic     halt;
   } mw_t;

endpackage

//--- rtl/register_file.sv
/* register file */
`timescale 1ns/1ps

module register_file
   import cpu_types_pkg::*;
(
   input  logic     CLK,
   input  logic     reset,
   input  logic     wen,
   input  regbits_t wsel,
   input  word_t    wdat,
   input  regbits_t rsel1,
   input  regbits_t rsel2,
   output word_t    rdat1,
   output word_t    rdat2
);
   word_t regs [32];

   // register 0 never written
   always_ff @(posedge CLK) begin
      if (reset) begin
         regs <= '{default: '0};
      end else if (wen && wsel != '0) begin
         regs[wsel] <= wdat;
      end
   end

   // same-cycle write shows up on the read side
   assign rdat1 = (wen && wsel != '0 && wsel == rsel1) ? wdat : regs[rsel1];
   assign rdat2 = (wen && wsel != '0 && wsel == rsel2) ? wdat : regs[rsel2];
endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the core testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
   --top-module tb_cpu_core \
   -f project.f \
   --Mdir obj_dir \
   -o sim_cpu_core
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/sim_cpu_core)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -qF "All tests passed!"; then
   exit 0
fi
exit 1

//--- verif/tb_clock_gen.sv
/* testbench clock */
`timescale 1ns/1ps

module tb_clock_gen #(
   parameter int PERIOD_NS = 4
) (
   output logic clk
);
   // starts low, first rising edge at half a period
   initial clk = 1'b0;

   always #(PERIOD_NS / 2) clk = ~clk;
endmodule

//--- verif/tb_cpu_core.sv
/* pipelined core testbench */
`timescale 1ns/1ps

module tb_cpu_core;
   // instruction encodings
   localparam logic [5:0] OP_RTYPE = 6'h00;
   localparam logic [5:0] OP_J     = 6'h02;
   localparam logic [5:0] OP_BEQ   = 6'h04;
   localparam logic [5:0] OP_BNE   = 6'h05;
   localparam logic [5:0] OP_ADDIU = 6'h09;
   localparam logic [5:0] OP_ORI   = 6'h0d;
   localparam logic [5:0] OP_LUI   = 6'h0f;
   localparam logic [5:0] OP_LW    = 6'h23;
   localparam logic [5:0] OP_SW    = 6'h2b;
   localparam logic [5:0] OP_HALT  = 6'h3f;
   localparam logic [5:0] FN_SLL   = 6'h00;
   localparam logic [5:0] FN_ADDU  = 6'h21;
   localparam logic [5:0] FN_SUBU  = 6'h23;
   localparam logic [5:0] FN_AND   = 6'h24;
   localparam logic [5:0] FN_OR    = 6'h25;
   localparam logic [5:0] FN_SLT   = 6'h2a;
   localparam int NUM_GROUPS = 4;
   // cycles watched once halt is up
   localparam int POST_HALT  = 20;

   logic        CLK, reset, ihit, dhit;
   logic [31:0] imem_load, dmem_load, imem_addr, dmem_addr, dmem_store;
   logic        dmem_ren, dmem_wen, halt;

   logic [31:0] rom [64];
   logic [31:0] ram [64];
   logic [31:0] exp_addr [$];
   logic [31:0] exp_data [$];
   int seed = 89390;
   int ref_count = 0;
   int limit = 100000;
   int cycles = 0;
   // bookkeeping of the compare process
   int errors = 0;
   int tests_run = 0;
   int tests_failed = 0;
   int n_seen = 0;
   int grp = 0;
   int grp_start = 0;
   int list_start = 0;
   int halt_start = 0;
   int post_halt = 0;
   bit reset_checked = 1'b0;
   bit halt_seen = 1'b0;
   bit done = 1'b0;
   // store count at which each group is complete
   int    group_end  [NUM_GROUPS] = '{8, 10, 12, 15};
   string group_name [NUM_GROUPS] = '{"alu forwarding", "load-use", "branch and jump", "loop"};

   tb_clock_gen #(.PERIOD_NS(4)) u_clock (.clk(CLK));

   cpu_core #(.PC_INIT(32'h0)) i_cpu_core (
      .CLK, .reset, .ihit, .dhit, .imem_load, .dmem_load,
      .imem_addr, .dmem_addr, .dmem_store, .dmem_ren, .dmem_wen, .halt
   );

   ////////////////////////////////////////////////////////////
   // encoders and memory contents
   ////////////////////////////////////////////////////////////
   function automatic logic [31:0] rtype_word(input logic [4:0] rs, input logic [4:0] rt,
                                              input logic [4:0] rd, input logic [4:0] sh,
                                              input logic [5:0] fn);
      return {OP_RTYPE, rs, rt, rd, sh, fn};
   endfunction

   function automatic logic [31:0] itype_word(input logic [5:0] op, input logic [4:0] rs,
                                              input logic [4:0] rt, input logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   // data ram reset contents
   // unique per word
   function automatic logic [31:0] fill_word(input int idx);
      return 32'h5a5a_0000 ^ (32'(idx) * 32'h0001_0211);
   endfunction

   // about 70 percent hits
   function automatic logic roll_hit();
      return ($unsigned($random(seed)) % 32'd100) < 32'd70;
   endfunction

   task automatic load_program();
      // halts with the word index in the low bits
      for (int i = 0; i < 64; i++) begin
         rom[i] = {OP_HALT, 26'(i)};
      end
      // dependent alu chain
      // each result stored right after it
      rom[0]  = itype_word(OP_ADDIU, 5'd0, 5'd1, 16'h0123);
      rom[1]  = itype_word(OP_ADDIU, 5'd0, 5'd2, 16'hfffb);
      rom[2]  = rtype_word(5'd1, 5'd2, 5'd3, 5'd0, FN_ADDU);
      rom[3]  = itype_word(OP_SW, 5'd0, 5'd3, 16'd0);
      rom[4]  = rtype_word(5'd3, 5'd1, 5'd4, 5'd0, FN_SUBU);
      rom[5]  = itype_word(OP_SW, 5'd0, 5'd4, 16'd4);
      rom[6]  = rtype_word(5'd4, 5'd2, 5'd5, 5'd0, FN_AND);
      rom[7]  = itype_word(OP_SW, 5'd0, 5'd5, 16'd8);
      rom[8]  = rtype_word(5'd5, 5'd1, 5'd6, 5'd0, FN_OR);
      rom[9]  = itype_word(OP_SW, 5'd0, 5'd6, 16'd12);
      rom[10] = rtype_word(5'd2, 5'd1, 5'd7, 5'd0, FN_SLT);
      rom[11] = itype_word(OP_SW, 5'd0, 5'd7, 16'd16);
      rom[12] = rtype_word(5'd0, 5'd1, 5'd8, 5'd4, FN_SLL);
      rom[13] = itype_word(OP_SW, 5'd0, 5'd8, 16'd20);
      rom[14] = itype_word(OP_ORI, 5'd2, 5'd9, 16'h8001);
      rom[15] = itype_word(OP_SW, 5'd0, 5'd9, 16'd24);
      rom[16] = itype_word(OP_LUI, 5'd0, 5'd10, 16'hbeef);
      rom[17] = itype_word(OP_SW, 5'd0, 5'd10, 16'd28);
      // loads used at once
      rom[18] = itype_word(OP_LW, 5'd0, 5'd11, 16'd64);
      rom[19] = rtype_word(5'd11, 5'd1, 5'd12, 5'd0, FN_ADDU);
      rom[20] = itype_word(OP_SW, 5'd0, 5'd12, 16'd32);
      rom[21] = itype_word(OP_LW, 5'd0, 5'd13, 16'd68);
      rom[22] = itype_word(OP_SW, 5'd0, 5'd13, 16'd36);
      // branches taken and not taken
      // wrong-path stores go to 40, 52 and 56
      rom[23] = itype_word(OP_BEQ, 5'd1, 5'd1, 16'd2);
      rom[24] = itype_word(OP_SW, 5'd0, 5'd1, 16'd40);
      rom[25] = itype_word(OP_SW, 5'd0, 5'd2, 16'd40);
      rom[26] = itype_word(OP_BNE, 5'd1, 5'd1, 16'd1);
      rom[27] = itype_word(OP_SW, 5'd0, 5'd3, 16'd44);
      rom[28] = itype_word(OP_BEQ, 5'd1, 5'd2, 16'd1);
      rom[29] = itype_word(OP_SW, 5'd0, 5'd4, 16'd48);
      rom[30] = itype_word(OP_BNE, 5'd1, 5'd2, 16'd1);
      rom[31] = itype_word(OP_SW, 5'd0, 5'd5, 16'd52);
      rom[32] = {OP_J, 26'd35};
      rom[33] = itype_word(OP_SW, 5'd0, 5'd6, 16'd56);
      rom[34] = itype_word(OP_SW, 5'd0, 5'd7, 16'd56);
      // three-pass loop
      // halt sits behind the back branch
      rom[35] = itype_word(OP_ADDIU, 5'd0, 5'd16, 16'd3);
      rom[36] = itype_word(OP_ADDIU, 5'd14, 5'd14, 16'd1);
      rom[37] = itype_word(OP_SW, 5'd0, 5'd14, 16'd60);
      rom[38] = itype_word(OP_BNE, 5'd14, 5'd16, 16'hfffd);
      rom[39] = {OP_HALT, 26'd0};
   endtask

   ////////////////////////////////////////////////////////////
   // reference interpreter
   ////////////////////////////////////////////////////////////
   // one instruction per step
   // fills the expected store list
   function automatic int run_reference();
      logic [31:0] rf [32];
      logic [31:0] dm [64];
      logic [31:0] pc, ins, a, b, simm, zimm, addr, next;
      logic [5:0]  op, fn;
      logic [4:0]  rs, rt, rd, sh;
      int          steps;
      bit          stop;
      for (int i = 0; i < 32; i++) begin
         rf[i] = 32'h0;
      end
      for (int i = 0; i < 64; i++) begin
         dm[i] = fill_word(i);
      end
      exp_addr.delete();
      exp_data.delete();
      pc = 32'h0;
      steps = 0;
      stop = 1'b0;
      while (!stop && steps < 5000) begin
         ins  = rom[pc[7:2]];
         op   = ins[31:26];
         rs   = ins[25:21];
         rt   = ins[20:16];
         rd   = ins[15:11];
         sh   = ins[10:6];
         fn   = ins[5:0];
         simm = {{16{ins[15]}}, ins[15:0]};
         zimm = {16'h0, ins[15:0]};
         a    = rf[rs];
         b    = rf[rt];
         addr = a + simm;
         next = pc + 32'd4;
         steps++;
         case (op)
            OP_RTYPE: begin
               case (fn)
                  FN_ADDU: rf[rd] = a + b;
                  FN_SUBU: rf[rd] = a - b;
                  FN_AND:  rf[rd] = a & b;
                  FN_OR:   rf[rd] = a | b;
                  FN_SLT:  rf[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                  FN_SLL:  rf[rd] = b << sh;
                  default: ;
               endcase
            end
            OP_ADDIU: rf[rt] = addr;
            OP_ORI:   rf[rt] = a | zimm;
            OP_LUI:   rf[rt] = {ins[15:0], 16'h0};
            OP_LW:    rf[rt] = dm[addr[7:2]];
            OP_SW: begin
               dm[addr[7:2]] = b;
               exp_addr.push_back(addr);
               exp_data.push_back(b);
            end
            OP_BEQ: if (a == b) next = next + (simm << 2);
            OP_BNE: if (a != b) next = next + (simm << 2);
            OP_J:    next = {next[31:28], ins[25:0], 2'b00};
            OP_HALT: stop = 1'b1;
            default: ;
         endcase
         rf[0] = 32'h0;
         pc = next;
      end
      return steps;
   endfunction

   ////////////////////////////////////////////////////////////
   // memories and stimulus
   ////////////////////////////////////////////////////////////
   assign imem_load = rom[imem_addr[7:2]];
   // read data only while a load is requested
   assign dmem_load = dmem_ren ? ram[dmem_addr[7:2]] : 32'h0;

   // ram refilled while reset is high
   always @(posedge CLK) begin
      if (reset) begin
         for (int i = 0; i < 64; i++) begin
            ram[i] <= fill_word(i);
         end
      end else if (dmem_wen && dhit) begin
         ram[dmem_addr[7:2]] <= dmem_store;
      end
   end

   initial begin
      reset = 1'b1;
      ihit  = 1'b0;
      dhit  = 1'b0;
      repeat (3) begin
         @(posedge CLK);
         ihit <= roll_hit();
         dhit <= roll_hit();
      end
      reset <= 1'b0;
      forever begin
         @(posedge CLK);
         ihit <= roll_hit();
         dhit <= roll_hit();
      end
   end

   ////////////////////////////////////////////////////////////
   // checking
   ////////////////////////////////////////////////////////////
   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] want);
      if (got !== want) begin
         $display("FAIL %s: got %h, expected %h", name, got, want);
         errors++;
      end
   endtask

   task automatic report_test(input string name, input int bad);
      tests_run++;
      if (bad == 0) begin
         $display("test %s: ok", name);
      end else begin
         tests_failed++;
         $display("test %s: failed with %0d mismatches", name, bad);
      end
   endtask

   task automatic log_store();
      if (halt) begin
         $display("store to address %h seen after halt", dmem_addr);
         errors++;
      end
      if (n_seen >= exp_addr.size()) begin
         $display("extra store to address %h beyond the expected list", dmem_addr);
         errors++;
      end else begin
         check_value("dmem_addr", dmem_addr, exp_addr[n_seen]);
         check_value("dmem_store", dmem_store, exp_data[n_seen]);
      end
      n_seen++;
      if (grp < NUM_GROUPS && n_seen == group_end[grp]) begin
         report_test(group_name[grp], errors - grp_start);
         grp++;
         grp_start = errors;
      end
   endtask

   // compare process on the rising edge
   always @(posedge CLK) begin
      if (!reset && !done) begin
         if (!reset_checked) begin
            check_value("halt", {31'b0, halt}, 32'h0);
            check_value("dmem_ren", {31'b0, dmem_ren}, 32'h0);
            check_value("dmem_wen", {31'b0, dmem_wen}, 32'h0);
            check_value("imem_addr", imem_addr, 32'h0);
            report_test("reset state", errors);
            grp_start = errors;
            list_start = errors;
            reset_checked = 1'b1;
         end
         if (dmem_wen && dhit) begin
            log_store();
         end
         if (halt_seen) begin
            if (!halt) begin
               $display("halt dropped after it had risen");
               errors++;
            end
            post_halt++;
            if (post_halt == POST_HALT) begin
               report_test("halt held", errors - halt_start);
               done = 1'b1;
            end
         end else if (halt) begin
            // every reference store done before halt
            halt_seen = 1'b1;
            check_value("store count", 32'(n_seen), 32'(exp_addr.size()));
            report_test("store list", errors - list_start);
            halt_start = errors;
         end
      end
   end

   // run limit from the reference length
   always @(posedge CLK) begin
      cycles <= cycles + 1;
      if (cycles >= limit) begin
         $display("timeout after %0d cycles, halt or the final checks never came", cycles);
         $display("Test failures found");
         $finish;
      end
   end

   initial begin
      load_program();
      ref_count = run_reference();
      limit = 20 * ref_count + 200;
      $display("reference: %0d instructions, %0d stores", ref_count, exp_addr.size());
      wait (done);
      $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
      if (errors == 0 && tests_failed == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end
endmodule
